//--- logic/ids_defs.svh
`ifndef IDS_DEFS_SVH
`define IDS_DEFS_SVH

// DFA state width, wide enough for any compiled pattern
`define IDS_STATE_W 11

// Stream id width and the number of streams it addresses
`define IDS_SID_W 6
`define IDS_NUM_STREAMS 64

// Packet match counter width
`define IDS_COUNT_W 16

// Beats buffered between framer and matcher
`define IDS_FIFO_DEPTH 16

// Control register byte offsets
`define IDS_REG_COUNT 4'h0
`define IDS_REG_EN_LO 4'h4
`define IDS_REG_EN_HI 4'h8

`endif

//--- logic/ids_pkg.sv
`include "ids_defs.svh"

package ids_pkg;

   // Header view of an ingress word
   typedef struct packed {
      logic [`IDS_SID_W-1:0] stream_id;
      logic                  new_stream;
      logic [7:0]            pad;
   } ingress_hdr_t;

   // Data view of an ingress word
   typedef struct packed {
      logic [7:0] character;
      logic       eop;
      logic [5:0] pad;
   } ingress_data_t;

   // One 15-bit ingress word, decoded by the separate is_hdr bit
   typedef union packed {
      ingress_hdr_t  hdr;
      ingress_data_t data;
   } ingress_word_u;

   // Beat from framer through FIFO to matcher
   typedef struct packed {
      logic                  load;
      logic                  new_stream;
      logic [`IDS_SID_W-1:0] stream_id;
      logic [7:0]            character;
      logic                  eop;
   } beat_t;

   // AXI4-Lite master to slave
   typedef struct packed {
      logic [3:0]  awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic        wvalid;
      logic        bready;
      logic [3:0]  araddr;
      logic        arvalid;
      logic        rready;
   } axil_req_t;

   // AXI4-Lite slave to master
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic [1:0]  bresp;
      logic        bvalid;
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
   } axil_rsp_t;

endpackage

//--- logic/passwd_dfa.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module passwd_dfa (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [7:0]              char_in,
   input  logic                    char_in_vld,
   input  logic [`IDS_STATE_W-1:0] state_in,
   input  logic                    state_in_vld,
   output logic [`IDS_STATE_W-1:0] state_out,
   output logic                    accept_out
);

   // Pattern characters, first at the top byte
   localparam logic [47:0] PATTERN = "passwd";

   logic [7:0] expect_char;

   // Character that extends the current partial match
   assign expect_char = PATTERN[47 - 8 * state_out[2:0] -: 8];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // A restored state wins over any character
         if (state_in_vld)
            state_out <= state_in;
         else if (char_in_vld)
         begin
            if (char_in == expect_char)
            begin
               if (state_out == `IDS_STATE_W'(5))
               begin
                  // Sixth character completes the pattern
                  state_out  <= '0;
                  accept_out <= 1'b1;
               end
               else
                  state_out <= state_out + 1'b1;
            end
            // No self-overlap, so only a 'p' keeps any progress
            else if (char_in == "p")
               state_out <= `IDS_STATE_W'(1);
            else
               state_out <= '0;
         end
      end
   end

endmodule

//--- logic/pkt_framer.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module pkt_framer
   import ids_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          in_valid,
   output logic          in_ready,
   input  logic          in_is_hdr,
   input  ingress_word_u in_word,
   output logic          beat_valid,
   input  logic          beat_ready,
   output beat_t         beat
);

   localparam int CNT_W = 8;

   // Zero means no open packet, else one plus the data words seen
   logic [CNT_W-1:0]      word_cnt;
   logic [`IDS_SID_W-1:0] cur_sid;
   logic                  pkt_open;
   logic                  xfer;

   assign pkt_open = (word_cnt != '0);
   assign in_ready = beat_ready;
   assign xfer     = in_valid && in_ready;

   // Decode the word by its is_hdr bit
   always_comb
   begin
      beat = '0;
      if (in_is_hdr)
      begin
         beat.load       = 1'b1;
         beat.new_stream = in_word.hdr.new_stream;
         beat.stream_id  = in_word.hdr.stream_id;
      end
      else
      begin
         // Data beats carry the id of the packet they belong to
         beat.stream_id = cur_sid;
         beat.character = in_word.data.character;
         beat.eop       = in_word.data.eop;
      end
   end

   // Stray data words are consumed but never forwarded
   assign beat_valid = in_valid && (in_is_hdr || pkt_open);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         word_cnt <= '0;
      end
      else if (xfer && in_is_hdr)
      begin
         word_cnt <= 1;
      end
      else if (xfer && pkt_open)
      begin
         if (in_word.data.eop)
            word_cnt <= '0;
         // Saturate so a long packet stays open
         else if (word_cnt != {CNT_W{1'b1}})
            word_cnt <= word_cnt + 1'b1;
      end
   end

   // Stream id of the open packet
   always_ff @(posedge clk)
   begin
      if (xfer && in_is_hdr)
         cur_sid <= in_word.hdr.stream_id;
   end

endmodule

//--- logic/beat_fifo.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module beat_fifo
   import ids_pkg::*;
#(
   parameter int DEPTH = `IDS_FIFO_DEPTH
)
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  wr_valid,
   output logic  wr_ready,
   input  beat_t wr_beat,
   output logic  rd_valid,
   input  logic  rd_ready,
   output beat_t rd_beat
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   beat_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             push;
   logic             pop;

   assign push     = wr_valid && wr_ready;
   assign pop      = rd_valid && rd_ready;
   assign rd_valid = (count != '0);
   assign rd_beat  = mem[rd_ptr];

   // Simultaneous push and pop leave the occupancy unchanged
   assign count_next = count + CNT_W'(push) - CNT_W'(pop);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         wr_ready <= 1'b0;
      end
      else
      begin
         count <= count_next;
         // Ready drops in the same cycle the buffer becomes full
         wr_ready <= (count_next != CNT_W'(DEPTH));
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= wr_beat;
   end

endmodule

//--- logic/stream_match_counter.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module stream_match_counter
   import ids_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        beat_valid,
   output logic                        beat_ready,
   input  beat_t                       beat,
   input  logic [`IDS_NUM_STREAMS-1:0] en_mask,
   output logic [`IDS_COUNT_W-1:0]     match_count
);

   // Saved DFA state per stream
   logic [`IDS_STATE_W-1:0] state_mem [`IDS_NUM_STREAMS];

   logic [`IDS_STATE_W-1:0] state_in;
   logic                    state_in_vld;
   logic [`IDS_STATE_W-1:0] state_out;
   logic                    accept_out;
   logic [`IDS_SID_W-1:0]   cur_sid;
   logic                    spec_match;
   logic                    fin1_q;
   logic                    fin2_q;
   logic                    take;
   logic                    save_en;

   // Stall while a state loads or a packet finalizes
   assign beat_ready = !(state_in_vld || fin1_q || fin2_q);
   assign take       = beat_valid && beat_ready;
   assign save_en    = fin2_q && en_mask[cur_sid];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
         fin1_q       <= 1'b0;
         fin2_q       <= 1'b0;
         spec_match   <= 1'b0;
         match_count  <= '0;
      end
      else
      begin
         state_in_vld <= take && beat.load;
         // First cycle sees the accept of the last character
         fin1_q <= take && beat.eop;
         fin2_q <= fin1_q;
         // Fresh flag for each packet
         if (take && beat.load)
            spec_match <= 1'b0;
         if (accept_out)
            spec_match <= 1'b1;
         // Finalize the packet on enabled streams only
         if (fin2_q)
         begin
            if (en_mask[cur_sid])
               match_count <= match_count + `IDS_COUNT_W'(spec_match);
            else
               spec_match <= 1'b0;
         end
      end
   end

   // Restore value for the DFA, zero for a stream never seen
   always_ff @(posedge clk)
   begin
      if (take && beat.load)
      begin
         cur_sid  <= beat.stream_id;
         state_in <= beat.new_stream ? '0 : state_mem[beat.stream_id];
      end
   end

   // State survives to the next packet of the stream
   always_ff @(posedge clk)
   begin
      if (save_en)
         state_mem[cur_sid] <= state_out;
   end

   passwd_dfa passwd_dfa_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (beat.character),
      .char_in_vld  (take && !beat.load),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

//--- logic/ids_csr.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module ids_csr
   import ids_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  axil_req_t                   host_req,
   output axil_rsp_t                   host_rsp,
   input  logic [`IDS_COUNT_W-1:0]     match_count,
   output logic [`IDS_NUM_STREAMS-1:0] en_mask
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic        bvalid_q;
   logic [1:0]  bresp_q;
   logic        rvalid_q;
   logic [1:0]  rresp_q;
   logic [31:0] rdata_q;
   logic        wr_fire;
   logic        rd_fire;
   logic        wr_hit;
   logic [31:0] rd_data;
   logic        rd_hit;

   // Address and data taken together, one write in flight
   assign wr_fire = host_req.awvalid && host_req.wvalid && !bvalid_q;
   assign rd_fire = host_req.arvalid && !rvalid_q;
   assign wr_hit  = (host_req.awaddr == `IDS_REG_EN_LO) ||
                    (host_req.awaddr == `IDS_REG_EN_HI);

   // Read decode
   always_comb
   begin
      rd_data = '0;
      rd_hit  = 1'b1;
      case (host_req.araddr)
         `IDS_REG_COUNT: rd_data = {{(32 - `IDS_COUNT_W){1'b0}}, match_count};
         `IDS_REG_EN_LO: rd_data = en_mask[31:0];
         `IDS_REG_EN_HI: rd_data = en_mask[63:32];
         default:        rd_hit  = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
         en_mask  <= '0;
      end
      else
      begin
         // Write channel
         if (wr_fire)
         begin
            bvalid_q <= 1'b1;
            if (host_req.awaddr == `IDS_REG_EN_LO)
               en_mask[31:0] <= host_req.wdata;
            if (host_req.awaddr == `IDS_REG_EN_HI)
               en_mask[63:32] <= host_req.wdata;
         end
         else if (host_req.bready)
            bvalid_q <= 1'b0;
         // Read channel
         if (rd_fire)
            rvalid_q <= 1'b1;
         else if (host_req.rready)
            rvalid_q <= 1'b0;
      end
   end

   // Response payload
   always_ff @(posedge clk)
   begin
      if (wr_fire)
         bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      if (rd_fire)
      begin
         rdata_q <= rd_data;
         rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
   end

   always_comb
   begin
      host_rsp         = '0;
      host_rsp.awready = wr_fire;
      host_rsp.wready  = wr_fire;
      host_rsp.bvalid  = bvalid_q;
      host_rsp.bresp   = bresp_q;
      host_rsp.arready = !rvalid_q;
      host_rsp.rvalid  = rvalid_q;
      host_rsp.rdata   = rdata_q;
      host_rsp.rresp   = rresp_q;
   end

endmodule

//--- logic/ids_top.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module ids_top
   import ids_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          in_valid,
   output logic          in_ready,
   input  logic          in_is_hdr,
   input  ingress_word_u in_word,
   input  axil_req_t     host_req,
   output axil_rsp_t     host_rsp
);

   // Framer to FIFO
   logic  fr_valid;
   logic  fr_ready;
   beat_t fr_beat;

   // FIFO to matcher
   logic  mt_valid;
   logic  mt_ready;
   beat_t mt_beat;

   logic [`IDS_NUM_STREAMS-1:0] en_mask;
   logic [`IDS_COUNT_W-1:0]     match_count;

   pkt_framer pkt_framer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_is_hdr  (in_is_hdr),
      .in_word    (in_word),
      .beat_valid (fr_valid),
      .beat_ready (fr_ready),
      .beat       (fr_beat)
   );

   beat_fifo #(
      .DEPTH (`IDS_FIFO_DEPTH)
   ) beat_fifo_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (fr_valid),
      .wr_ready (fr_ready),
      .wr_beat  (fr_beat),
      .rd_valid (mt_valid),
      .rd_ready (mt_ready),
      .rd_beat  (mt_beat)
   );

   stream_match_counter stream_match_counter_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_valid  (mt_valid),
      .beat_ready  (mt_ready),
      .beat        (mt_beat),
      .en_mask     (en_mask),
      .match_count (match_count)
   );

   ids_csr ids_csr_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_req    (host_req),
      .host_rsp    (host_rsp),
      .match_count (match_count),
      .en_mask     (en_mask)
   );

endmodule

//--- testbench/tb_ids_top.sv
`timescale 1ns/1ps
`include "ids_defs.svh"

module tb_ids_top
   import ids_pkg::*;
();

   localparam int         WAIT_LIMIT    = 1000;
   localparam int         POLL_LIMIT    = 200;
   localparam int         STABLE_READS  = 10;
   localparam int         BURST_PACKETS = 24;
   localparam logic [3:0] REG_UNMAPPED  = 4'hc;
   localparam logic [1:0] RESP_OKAY     = 2'b00;
   localparam logic [1:0] RESP_SLVERR   = 2'b10;

   logic          clk;
   logic          rst_n;
   logic          in_valid;
   logic          in_ready;
   logic          in_is_hdr;
   ingress_word_u in_word;
   axil_req_t     host_req;
   axil_rsp_t     host_rsp;

   // Reference model: per-stream progress, mask and expected count
   int          progress [`IDS_NUM_STREAMS];
   bit          saved [`IDS_NUM_STREAMS];
   logic [63:0] exp_mask;
   int          exp_count;

   integer seed;
   int     errors;
   int     test_errors;
   int     tests_run;
   int     tests_failed;
   bit     hang;
   bit     saw_full;

   ids_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_is_hdr (in_is_hdr),
      .in_word   (in_word),
      .host_req  (host_req),
      .host_rsp  (host_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      $display("Fail at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
      test_errors++;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0d ns while waiting for %s", $time, what);
      test_errors++;
      hang = 1'b1;
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      int n;
      resp = 2'b11;
      if (hang)
         return;
      @(negedge clk);
      host_req.awaddr  = addr;
      host_req.awvalid = 1'b1;
      host_req.wdata   = data;
      host_req.wvalid  = 1'b1;
      #1;
      n = 0;
      // Address and data go in on the same edge
      while (!(host_rsp.awready && host_rsp.wready) && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      if (!(host_rsp.awready && host_rsp.wready))
      begin
         report_timeout("write address and data acceptance");
         return;
      end
      @(negedge clk);
      host_req.awvalid = 1'b0;
      host_req.wvalid  = 1'b0;
      host_req.bready  = 1'b1;
      #1;
      n = 0;
      while (!host_rsp.bvalid && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      if (!host_rsp.bvalid)
      begin
         report_timeout("write response");
         return;
      end
      resp = host_rsp.bresp;
      @(negedge clk);
      host_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      data = '0;
      resp = 2'b11;
      if (hang)
         return;
      @(negedge clk);
      host_req.araddr  = addr;
      host_req.arvalid = 1'b1;
      #1;
      n = 0;
      while (!host_rsp.arready && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      if (!host_rsp.arready)
      begin
         report_timeout("read address acceptance");
         return;
      end
      @(negedge clk);
      host_req.arvalid = 1'b0;
      host_req.rready  = 1'b1;
      #1;
      n = 0;
      while (!host_rsp.rvalid && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      if (!host_rsp.rvalid)
      begin
         report_timeout("read data");
         return;
      end
      data = host_rsp.rdata;
      resp = host_rsp.rresp;
      @(negedge clk);
      host_req.rready = 1'b0;
   endtask

   // One ingress word, held until in_ready lets it through
   task automatic send_word(input logic is_hdr, input ingress_word_u word);
      int n;
      if (hang)
         return;
      @(negedge clk);
      in_valid  = 1'b1;
      in_is_hdr = is_hdr;
      in_word   = word;
      #1;
      n = 0;
      while (!in_ready && n < WAIT_LIMIT)
      begin
         saw_full = 1'b1;
         @(negedge clk);
         #1;
         n++;
      end
      if (!in_ready)
         report_timeout("ingress ready");
   endtask

   task automatic release_input();
      @(negedge clk);
      in_valid  = 1'b0;
      in_is_hdr = 1'b0;
      in_word   = '0;
   endtask

   // Next match progress, 6 means the pattern just completed
   function automatic int next_state(input int st, input byte unsigned c);
      string pat;
      int    nx;
      pat = "passwd";
      if (c == pat[st])
         nx = st + 1;
      else if (c == "p")
         nx = 1;
      else
         nx = 0;
      return nx;
   endfunction

   task automatic model_packet(input int sid, input bit new_stream, input string text);
      int st;
      int nx;
      bit hit;
      st  = new_stream ? 0 : progress[sid];
      hit = 1'b0;
      for (int i = 0; i < text.len(); i++)
      begin
         nx = next_state(st, text[i]);
         if (nx == 6)
         begin
            hit = 1'b1;
            st  = 0;
         end
         else
            st = nx;
      end
      // Disabled streams neither count nor keep their progress
      if (exp_mask[sid])
      begin
         exp_count += int'(hit);
         progress[sid] = st;
         saved[sid] = 1'b1;
      end
   endtask

   task automatic send_packet(input int sid, input bit new_stream, input string text);
      ingress_word_u w;
      w = '0;
      w.hdr.stream_id  = `IDS_SID_W'(sid);
      w.hdr.new_stream = new_stream;
      send_word(1'b1, w);
      for (int i = 0; i < text.len(); i++)
      begin
         w = '0;
         w.data.character = text[i];
         w.data.eop       = (i == text.len() - 1);
         send_word(1'b0, w);
      end
      model_packet(sid, new_stream, text);
   endtask

   // Filler never holds a pattern letter
   function automatic string rand_fill(input int n);
      string allowed;
      string s;
      int    idx;
      allowed = "bcefghijklmnoqrtuvxyz";
      s = "";
      for (int i = 0; i < n; i++)
      begin
         idx = int'($unsigned($random(seed)) % allowed.len());
         s = {s, allowed.substr(idx, idx)};
      end
      return s;
   endfunction

   // Count must reach its value, then hold it while the pipeline drains
   task automatic expect_count(input int expected);
      logic [31:0] data;
      logic [1:0]  resp;
      int          n;
      int          stable;
      if (hang)
         return;
      axil_read(`IDS_REG_COUNT, data, resp);
      n = 0;
      while (data !== 32'(expected) && n < POLL_LIMIT && !hang)
      begin
         axil_read(`IDS_REG_COUNT, data, resp);
         n++;
      end
      stable = 0;
      while (data === 32'(expected) && stable < STABLE_READS && !hang)
      begin
         axil_read(`IDS_REG_COUNT, data, resp);
         stable++;
      end
      if (hang)
         return;
      if (data !== 32'(expected))
         report_mismatch("match_count", data, 32'(expected));
      if (resp !== RESP_OKAY)
         report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      errors += test_errors;
      if (test_errors == 0)
         $display("Test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("Test %s: %0d errors", name, test_errors);
      end
   endtask

   task automatic test_register_access();
      logic [31:0] data;
      logic [1:0]  resp;
      test_errors = 0;
      // Streams 12 and 40 stay disabled
      axil_write(`IDS_REG_EN_LO, 32'hffff_efff, resp);
      if (resp !== RESP_OKAY)
         report_mismatch("bresp", 32'(resp), 32'(RESP_OKAY));
      axil_write(`IDS_REG_EN_HI, 32'h8000_0421, resp);
      if (resp !== RESP_OKAY)
         report_mismatch("bresp", 32'(resp), 32'(RESP_OKAY));
      exp_mask = {32'h8000_0421, 32'hffff_efff};
      axil_read(`IDS_REG_EN_LO, data, resp);
      if (data !== exp_mask[31:0])
         report_mismatch("rdata en_lo", data, exp_mask[31:0]);
      if (resp !== RESP_OKAY)
         report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
      axil_read(`IDS_REG_EN_HI, data, resp);
      if (data !== exp_mask[63:32])
         report_mismatch("rdata en_hi", data, exp_mask[63:32]);
      if (resp !== RESP_OKAY)
         report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
      axil_read(REG_UNMAPPED, data, resp);
      if (data !== 32'h0)
         report_mismatch("rdata unmapped", data, 32'h0);
      if (resp !== RESP_SLVERR)
         report_mismatch("rresp", 32'(resp), 32'(RESP_SLVERR));
      // Unmapped write is refused and changes nothing
      axil_write(REG_UNMAPPED, 32'h1234_5678, resp);
      if (resp !== RESP_SLVERR)
         report_mismatch("bresp", 32'(resp), 32'(RESP_SLVERR));
      axil_read(`IDS_REG_EN_LO, data, resp);
      if (data !== exp_mask[31:0])
         report_mismatch("rdata en_lo", data, exp_mask[31:0]);
      expect_count(0);
      finish_test("register access");
   endtask

   task automatic test_single_match();
      string pkt;
      test_errors = 0;
      pkt = rand_fill(3);
      pkt = {pkt, "passwd", rand_fill(2)};
      send_packet(5, 1'b1, pkt);
      // Two hits in one packet still count once
      pkt = rand_fill(1);
      pkt = {pkt, "passwd", rand_fill(2), "passwd", rand_fill(1)};
      send_packet(9, 1'b1, pkt);
      release_input();
      expect_count(exp_count);
      finish_test("single match");
   endtask

   task automatic test_disabled_stream();
      string pkt;
      test_errors = 0;
      pkt = rand_fill(2);
      pkt = {pkt, "passwd", rand_fill(3)};
      send_packet(12, 1'b1, pkt);
      send_packet(40, 1'b1, pkt);
      release_input();
      expect_count(exp_count);
      finish_test("disabled stream");
   endtask

   task automatic test_split_signature();
      test_errors = 0;
      send_packet(5, 1'b1, "pas");
      send_packet(9, 1'b0, rand_fill(4));
      send_packet(5, 1'b0, "swd");
      release_input();
      expect_count(exp_count);
      // A fresh stream forgets the saved prefix
      send_packet(5, 1'b1, "pas");
      send_packet(9, 1'b0, rand_fill(4));
      send_packet(5, 1'b1, "swd");
      release_input();
      expect_count(exp_count);
      finish_test("split signature");
   endtask

   function automatic int burst_stream(input int k);
      int sid;
      case (k)
         0:       sid = 1;
         1:       sid = 12;
         2:       sid = 37;
         3:       sid = 40;
         4:       sid = 63;
         default: sid = 5;
      endcase
      return sid;
   endfunction

   function automatic string fragment(input int k);
      string s;
      case (k)
         0:       s = "passwd";
         1:       s = "pas";
         2:       s = "swd";
         3:       s = "passw";
         4:       s = "ppasswdpasswd";
         5:       s = "d";
         default: s = "sswd";
      endcase
      return s;
   endfunction

   task automatic test_back_pressure();
      string pkt;
      int    sid;
      bit    new_flag;
      test_errors = 0;
      saw_full = 1'b0;
      for (int k = 0; k < BURST_PACKETS; k++)
      begin
         sid = burst_stream(int'($unsigned($random(seed)) % 6));
         new_flag = ($random(seed) & 1) != 0;
         // Streams without saved progress must start fresh
         if (!saved[sid])
            new_flag = 1'b1;
         pkt = rand_fill(int'($unsigned($random(seed)) % 4));
         pkt = {pkt, fragment(int'($unsigned($random(seed)) % 7))};
         pkt = {pkt, rand_fill(int'($unsigned($random(seed)) % 3))};
         send_packet(sid, new_flag, pkt);
      end
      release_input();
      if (!saw_full && !hang)
      begin
         $display("Error at %0d ns: in_ready never fell during the burst", $time);
         test_errors++;
      end
      expect_count(exp_count);
      finish_test("back-pressure");
   endtask

   initial
   begin
      seed = 32'h9f5721cd;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      hang = 1'b0;
      saw_full = 1'b0;
      exp_mask = '0;
      exp_count = 0;
      for (int i = 0; i < `IDS_NUM_STREAMS; i++)
      begin
         progress[i] = 0;
         saved[i] = 1'b0;
      end
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_is_hdr = 1'b0;
      in_word = '0;
      host_req = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_register_access();
      if (!hang)
         test_single_match();
      if (!hang)
         test_disabled_stream();
      if (!hang)
         test_split_signature();
      if (!hang)
         test_back_pressure();
      $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0 && !hang)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- files.f
+incdir+logic
logic/ids_pkg.sv
logic/passwd_dfa.sv
logic/pkt_framer.sv
logic/beat_fifo.sv
logic/stream_match_counter.sv
logic/ids_csr.sv
logic/ids_top.sv
testbench/tb_ids_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the IDS testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_ids_top -f files.f -o sim_tb_ids_top
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb_ids_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
   exit 0
fi
exit 1
